// ==== common/dl1_addr_pkg.sv ====
/*
 * Address view types of the L1 data cache
 * Field widths, the field struct and the address union
 * Line and line address types
 */

`include "dl1_macros.svh"

package dl1_addr_pkg;

	localparam int DL1_BYTE_OFF_W = 2;
	localparam int DL1_WORD_OFF_W = $clog2(`DL1_LINE_WORDS);
	localparam int DL1_INDEX_W = $clog2(`DL1_SETS);
	localparam int DL1_TAG_W = `DL1_ADDR_W - DL1_INDEX_W - DL1_WORD_OFF_W - DL1_BYTE_OFF_W;

	typedef logic [DL1_TAG_W-1:0] dl1_tag_t;
	typedef logic [DL1_INDEX_W-1:0] dl1_index_t;
	typedef logic [DL1_WORD_OFF_W-1:0] dl1_word_off_t;

	// Lookup view, tag in the upper bits
	typedef struct packed {
		dl1_tag_t tag;
		dl1_index_t index;
		dl1_word_off_t word_off;
		logic [DL1_BYTE_OFF_W-1:0] byte_off;
	} dl1_addr_fields_t;

	// Same address as a flat bus word or as lookup fields
	typedef union packed {
		logic [`DL1_ADDR_W-1:0] word;
		dl1_addr_fields_t fields;
	} dl1_addr_u;

	// Word 0 sits in the low bits
	typedef logic [`DL1_LINE_WORDS-1:0][`DL1_ADDR_W-1:0] dl1_line_t;

	typedef struct packed {
		dl1_tag_t tag;
		dl1_index_t index;
	} dl1_line_addr_t;

endpackage

// ==== common/dl1_bus_pkg.sv ====
/*
 * Bus structs of the L1 data cache
 * Held CPU request, memory request and memory response
 */

`include "dl1_macros.svh"

package dl1_bus_pkg;

	//========================================
	// CPU side
	//========================================

	// One APB transfer as seen by the lookup
	typedef struct packed {
		dl1_addr_pkg::dl1_addr_u addr;
		logic write;
		logic [`DL1_ADDR_W-1:0] wdata;
	} dl1_cpu_req_t;

	//========================================
	// Memory side
	//========================================

	// Held stable from req rise until ack is seen
	typedef struct packed {
		logic req;
		logic we;
		dl1_addr_pkg::dl1_line_addr_t line_addr;
		dl1_addr_pkg::dl1_line_t wline;
	} dl1_mem_req_t;

	// ack is a single cycle pulse
	// rline is only meaningful with ack of a read
	typedef struct packed {
		logic ack;
		dl1_addr_pkg::dl1_line_t rline;
	} dl1_mem_rsp_t;

endpackage

// ==== common/dl1_macros.svh ====
/*
 * Size parameters of the L1 data cache
 * Address and data width, words per line, sets and ways
 */

`ifndef DL1_MACROS_SVH
`define DL1_MACROS_SVH

//========================================
// Geometry
//========================================

// Address and data bus width
`define DL1_ADDR_W 32

// Words in one cache line
`define DL1_LINE_WORDS 4

// Sets per way
`define DL1_SETS 16

// Associativity
`define DL1_WAYS 2

`endif

// ==== dl1_cache/dl1_controller.sv ====
/*
 * Miss controller of the L1 data cache
 * FSM for lookup, eviction, refill and response
 * Memory request/acknowledge handshake and APB response
 */

`timescale 1ns/1ps

`include "dl1_macros.svh"

module dl1_controller (
	input  logic                           clk_l1,
	input  logic                           rst_n,
	input  logic                           req_valid,
	input  dl1_bus_pkg::dl1_cpu_req_t      cpu_req,
	input  logic                           hit,
	input  logic                           hit_way,
	input  logic [`DL1_ADDR_W-1:0]         rd_word,
	input  logic                           victim_way,
	input  logic                           victim_dirty,
	input  dl1_addr_pkg::dl1_line_t        victim_line,
	input  dl1_addr_pkg::dl1_line_addr_t   victim_line_addr,
	input  dl1_bus_pkg::dl1_mem_rsp_t      mem_rsp,
	output dl1_bus_pkg::dl1_mem_req_t      mem_req,
	output logic                           wr_hit,
	output logic                           fill,
	output logic                           touch,
	output dl1_addr_pkg::dl1_line_t        fill_line,
	output logic                           pready,
	output logic [`DL1_ADDR_W-1:0]         prdata,
	output logic                           pslverr
);

	import dl1_addr_pkg::*;

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_EVICT,
		ST_REFILL,
		ST_RESPOND
	} state_t;

	state_t state;
	logic respond;
	logic miss;
	logic req_q;
	logic we_q;
	dl1_line_addr_t line_addr_q;
	dl1_line_t wline_q;
	dl1_line_addr_t refill_addr;

	assign refill_addr = '{tag: cpu_req.addr.fields.tag,
		index: cpu_req.addr.fields.index};

	// Lookup happens in IDLE, and once more after the refill
	assign respond = req_valid && hit && ((state == ST_IDLE) || (state == ST_RESPOND));
	assign miss = (state == ST_IDLE) && req_valid && !hit;

	//========================================
	// APB side and array controls
	//========================================

	assign pready = respond;
	assign prdata = rd_word;
	assign pslverr = 1'b0;
	assign wr_hit = respond && cpu_req.write;
	assign touch = respond;

	// Line written on the ack cycle of the read
	assign fill = (state == ST_REFILL) && req_q && mem_rsp.ack;
	assign fill_line = mem_rsp.rline;

	//========================================
	// FSM and handshake
	//========================================

	always_ff @(posedge clk_l1 or negedge rst_n)
	begin
		if (!rst_n)
		begin
			state <= ST_IDLE;
			req_q <= 1'b0;
		end
		else
		begin
			case (state)
				ST_IDLE:
				begin
					if (miss)
					begin
						req_q <= 1'b1;
						state <= victim_dirty ? ST_EVICT : ST_REFILL;
					end
				end
				ST_EVICT:
				begin
					if (req_q && mem_rsp.ack)
					begin
						req_q <= 1'b0;
						state <= ST_REFILL;
					end
				end
				ST_REFILL:
				begin
					// Read goes out one cycle after the eviction ack
					if (!req_q)
						req_q <= 1'b1;
					else if (mem_rsp.ack)
					begin
						req_q <= 1'b0;
						state <= ST_RESPOND;
					end
				end
				default:
					state <= ST_IDLE;
			endcase
		end
	end

	// Request payload
	always_ff @(posedge clk_l1)
	begin
		if (miss)
		begin
			we_q <= victim_dirty;
			line_addr_q <= victim_dirty ? victim_line_addr : refill_addr;
			wline_q <= victim_line;
		end
		else if ((state == ST_REFILL) && !req_q)
		begin
			we_q <= 1'b0;
			line_addr_q <= refill_addr;
		end
	end

	assign mem_req = '{req: req_q, we: we_q, line_addr: line_addr_q, wline: wline_q};

	//========================================
	// Checks
	//========================================

	a_mem_req_stable: assert property (
		@(posedge clk_l1) disable iff (!rst_n)
		(mem_req.req && !mem_rsp.ack) |=>
			(mem_req.req && $stable(mem_req.we) &&
			$stable(mem_req.line_addr) && $stable(mem_req.wline))
	);

	// Refilled way is the one that hits afterwards
	a_refill_hits: assert property (
		@(posedge clk_l1) disable iff (!rst_n)
		(state == ST_RESPOND) |-> (hit && (hit_way == $past(victim_way)))
	);

endmodule

// ==== dl1_cache/dl1_way_array.sv ====
/*
 * Two way storage of the L1 data cache
 * Tag, valid, dirty and data arrays, hit compare, LRU bits
 * Victim choice and victim line readout
 */

`timescale 1ns/1ps

`include "dl1_macros.svh"

module dl1_way_array (
	input  logic                           clk_l1,
	input  logic                           rst_n,
	input  dl1_bus_pkg::dl1_cpu_req_t      cpu_req,
	input  logic                           req_valid,
	input  logic                           wr_hit,
	input  logic                           fill,
	input  logic                           touch,
	input  dl1_addr_pkg::dl1_line_t        fill_line,
	output logic                           hit,
	output logic                           hit_way,
	output logic [`DL1_ADDR_W-1:0]         rd_word,
	output logic                           victim_way,
	output logic                           victim_dirty,
	output dl1_addr_pkg::dl1_line_t        victim_line,
	output dl1_addr_pkg::dl1_line_addr_t   victim_line_addr
);

	import dl1_addr_pkg::*;

	dl1_tag_t tag_mem [`DL1_WAYS][`DL1_SETS];
	dl1_line_t data_mem [`DL1_WAYS][`DL1_SETS];
	logic [`DL1_SETS-1:0] valid_q [`DL1_WAYS];
	logic [`DL1_SETS-1:0] dirty_q [`DL1_WAYS];
	// Set bit names the least recently used way
	logic [`DL1_SETS-1:0] lru_q;
	logic [`DL1_WAYS-1:0] way_hit;
	dl1_addr_fields_t fields;

	assign fields = cpu_req.addr.fields;

	//========================================
	// Lookup
	//========================================

	always_comb
	begin
		for (int w = 0; w < `DL1_WAYS; w++)
		begin
			way_hit[w] = valid_q[w][fields.index] &&
				(tag_mem[w][fields.index] == fields.tag);
		end
	end

	assign hit = req_valid && (|way_hit);
	assign hit_way = way_hit[1];
	assign rd_word = data_mem[hit_way][fields.index][fields.word_off];

	// Empty way first, LRU way otherwise
	always_comb
	begin
		if (!valid_q[0][fields.index])
			victim_way = 1'b0;
		else if (!valid_q[1][fields.index])
			victim_way = 1'b1;
		else
			victim_way = lru_q[fields.index];
	end

	assign victim_dirty = dirty_q[victim_way][fields.index];
	assign victim_line = data_mem[victim_way][fields.index];
	assign victim_line_addr = '{tag: tag_mem[victim_way][fields.index],
		index: fields.index};

	//========================================
	// Updates
	//========================================

	always_ff @(posedge clk_l1)
	begin
		if (fill)
		begin
			tag_mem[victim_way][fields.index] <= fields.tag;
			data_mem[victim_way][fields.index] <= fill_line;
		end
		else if (wr_hit)
			data_mem[hit_way][fields.index][fields.word_off] <= cpu_req.wdata;
	end

	always_ff @(posedge clk_l1 or negedge rst_n)
	begin
		if (!rst_n)
		begin
			for (int w = 0; w < `DL1_WAYS; w++)
			begin
				valid_q[w] <= '0;
				dirty_q[w] <= '0;
			end
			lru_q <= '0;
		end
		else
		begin
			// Refilled line is clean
			if (fill)
			begin
				valid_q[victim_way][fields.index] <= 1'b1;
				dirty_q[victim_way][fields.index] <= 1'b0;
			end
			else if (wr_hit)
				dirty_q[hit_way][fields.index] <= 1'b1;
			// Other way becomes LRU
			if (touch)
				lru_q[fields.index] <= ~hit_way;
		end
	end

	a_one_way_hit: assert property (
		@(posedge clk_l1) disable iff (!rst_n)
		!(way_hit[0] && way_hit[1])
	);

endmodule

// ==== files.f ====
+incdir+common
common/dl1_addr_pkg.sv
common/dl1_bus_pkg.sv
source/dl1_req_decode.sv
dl1_cache/dl1_way_array.sv
dl1_cache/dl1_controller.sv
source/dl1_top.sv
verif/dl1_mem_model.sv
verif/dl1_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the L1 data cache testbench with Verilator.
# The verdict comes from the simulation output, no log file is kept.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
	-f files.f --top-module dl1_tb -Mdir obj_dir -o dl1_sim \
	&& ./obj_dir/dl1_sim | tee /dev/stderr | grep -x "TEST PASS" > /dev/null \
	&& echo "Simulation passed" \
	|| { echo "Simulation failed"; exit 1; }

// ==== source/dl1_req_decode.sv ====
/*
 * APB request capture
 * Registers address, direction and data at the setup phase
 * and holds them with req_valid until the transfer ends
 */

`timescale 1ns/1ps

`include "dl1_macros.svh"

module dl1_req_decode (
	input  logic                        clk_l1,
	input  logic                        rst_n,
	input  logic                        psel,
	input  logic                        penable,
	input  logic                        pwrite,
	input  logic [`DL1_ADDR_W-1:0]      paddr,
	input  logic [`DL1_ADDR_W-1:0]      pwdata,
	input  logic                        pready,
	output dl1_bus_pkg::dl1_cpu_req_t   cpu_req,
	output logic                        req_valid
);

	logic setup_phase;
	logic access_done;

	assign setup_phase = psel && !penable;
	assign access_done = psel && penable && pready;

	// Request fields, loaded once per transfer
	always_ff @(posedge clk_l1)
	begin
		if (setup_phase)
		begin
			cpu_req.addr.word <= paddr;
			cpu_req.write <= pwrite;
			cpu_req.wdata <= pwdata;
		end
	end

	// Valid through the access phase
	always_ff @(posedge clk_l1 or negedge rst_n)
	begin
		if (!rst_n)
			req_valid <= 1'b0;
		else if (setup_phase)
			req_valid <= 1'b1;
		else if (access_done)
			req_valid <= 1'b0;
	end

	//========================================
	// Protocol check
	//========================================

	a_penable_needs_psel: assert property (
		@(posedge clk_l1) disable iff (!rst_n)
		penable |-> psel
	);

endmodule

// ==== source/dl1_top.sv ====
/*
 * L1 data cache top level
 * APB completer on the CPU side, line handshake to memory
 */

`timescale 1ns/1ps

`include "dl1_macros.svh"

module dl1_top (
	input  logic                        clk_l1,
	input  logic                        rst_n,
	input  logic                        psel,
	input  logic                        penable,
	input  logic [`DL1_ADDR_W-1:0]      paddr,
	input  logic                        pwrite,
	input  logic [`DL1_ADDR_W-1:0]      pwdata,
	output logic                        pready,
	output logic [`DL1_ADDR_W-1:0]      prdata,
	output logic                        pslverr,
	input  dl1_bus_pkg::dl1_mem_rsp_t   mem_rsp,
	output dl1_bus_pkg::dl1_mem_req_t   mem_req
);

	import dl1_addr_pkg::*;
	import dl1_bus_pkg::*;

	dl1_cpu_req_t cpu_req;
	logic req_valid;
	logic hit;
	logic hit_way;
	logic [`DL1_ADDR_W-1:0] rd_word;
	logic victim_way;
	logic victim_dirty;
	dl1_line_t victim_line;
	dl1_line_addr_t victim_line_addr;
	logic wr_hit;
	logic fill;
	logic touch;
	dl1_line_t fill_line;

	// Request capture
	dl1_req_decode dl1_req_decode_inst (
		.clk_l1(clk_l1), .rst_n(rst_n), .psel(psel), .penable(penable),
		.pwrite(pwrite), .paddr(paddr), .pwdata(pwdata), .pready(pready),
		.cpu_req(cpu_req), .req_valid(req_valid)
	);

	// Storage and lookup
	dl1_way_array dl1_way_array_inst (
		.clk_l1(clk_l1), .rst_n(rst_n), .cpu_req(cpu_req), .req_valid(req_valid),
		.wr_hit(wr_hit), .fill(fill), .touch(touch), .fill_line(fill_line),
		.hit(hit), .hit_way(hit_way), .rd_word(rd_word),
		.victim_way(victim_way), .victim_dirty(victim_dirty),
		.victim_line(victim_line), .victim_line_addr(victim_line_addr)
	);

	// Miss handling and response
	dl1_controller dl1_controller_inst (
		.clk_l1(clk_l1), .rst_n(rst_n), .req_valid(req_valid), .cpu_req(cpu_req),
		.hit(hit), .hit_way(hit_way), .rd_word(rd_word),
		.victim_way(victim_way), .victim_dirty(victim_dirty),
		.victim_line(victim_line), .victim_line_addr(victim_line_addr),
		.mem_rsp(mem_rsp), .mem_req(mem_req),
		.wr_hit(wr_hit), .fill(fill), .touch(touch), .fill_line(fill_line),
		.pready(pready), .prdata(prdata), .pslverr(pslverr)
	);

endmodule

// ==== verif/dl1_mem_model.sv ====
/*
 * Next level memory for the L1 data cache testbench
 * Line handshake with a random acknowledge delay
 * Read and write counters
 */

`timescale 1ns/1ps

`include "dl1_macros.svh"

module dl1_mem_model (
	input  logic                        clk_l1,
	input  logic                        rst_n,
	input  dl1_bus_pkg::dl1_mem_req_t   mem_req,
	output dl1_bus_pkg::dl1_mem_rsp_t   mem_rsp,
	output int unsigned                 read_count,
	output int unsigned                 write_count
);

	import dl1_addr_pkg::*;
	import dl1_bus_pkg::*;

	localparam logic [31:0] SEED = 32'h2eb9_b1a9;

	// Lines written back so far, keyed by line address
	dl1_line_t lines [dl1_line_addr_t];
	logic busy;
	logic [2:0] wait_cnt;
	bit seeded = 1'b0;

	// Untouched words hold their byte address XOR a fixed mark
	function automatic dl1_line_t fetch_line(input dl1_line_addr_t line_addr);
		dl1_line_t line;
		if (lines.exists(line_addr))
			return lines[line_addr];
		for (int w = 0; w < `DL1_LINE_WORDS; w++)
			line[w] = {line_addr, 2'(w), 2'b00} ^ 32'hA5A5_0000;
		return line;
	endfunction

	//========================================
	// Handshake
	//========================================

	always @(posedge clk_l1 or negedge rst_n)
	begin
		if (!rst_n)
		begin
			mem_rsp <= '0;
			busy <= 1'b0;
			wait_cnt <= '0;
			read_count <= 0;
			write_count <= 0;
		end
		else
		begin
			mem_rsp.ack <= 1'b0;
			if (busy)
			begin
				if (wait_cnt == 3'd1)
				begin
					busy <= 1'b0;
					mem_rsp.ack <= 1'b1;
					if (mem_req.we)
					begin
						lines[mem_req.line_addr] = mem_req.wline;
						write_count <= write_count + 1;
					end
					else
					begin
						mem_rsp.rline <= fetch_line(mem_req.line_addr);
						read_count <= read_count + 1;
					end
				end
				else
					wait_cnt <= wait_cnt - 3'd1;
			end
			// New request, but not in the cycle right after an ack
			else if (mem_req.req && !mem_rsp.ack)
			begin
				if (!seeded)
				begin
					void'($urandom(SEED));
					seeded = 1'b1;
				end
				busy <= 1'b1;
				wait_cnt <= 3'($urandom % 6 + 1);
			end
		end
	end

endmodule

// ==== verif/dl1_tb.sv ====
/*
 * Testbench for the L1 data cache
 * Clock, reset, transfer table, checks, timeout and verdict
 */

`timescale 1ns/1ps

`include "dl1_macros.svh"

module dl1_tb;

	import dl1_bus_pkg::*;

	// One APB transfer with its expected outcome
	typedef struct packed {
		logic write;
		logic [`DL1_ADDR_W-1:0] addr;
		logic [`DL1_ADDR_W-1:0] wdata;
		logic [`DL1_ADDR_W-1:0] exp_rdata;
		logic [3:0] exp_reads;
		logic [3:0] exp_writes;
	} xfer_t;

	logic clk_l1;
	logic rst_n;
	logic psel;
	logic penable;
	logic [`DL1_ADDR_W-1:0] paddr;
	logic pwrite;
	logic [`DL1_ADDR_W-1:0] pwdata;
	logic pready;
	logic [`DL1_ADDR_W-1:0] prdata;
	logic pslverr;
	dl1_mem_req_t mem_req;
	dl1_mem_rsp_t mem_rsp;
	int unsigned read_count;
	int unsigned write_count;
	xfer_t xfers [$];
	int timeout_limit;
	int data_errors;
	int traffic_errors;
	int protocol_errors;

	dl1_top dl1_top_inst (
		.clk_l1(clk_l1), .rst_n(rst_n), .psel(psel), .penable(penable),
		.paddr(paddr), .pwrite(pwrite), .pwdata(pwdata), .pready(pready),
		.prdata(prdata), .pslverr(pslverr), .mem_rsp(mem_rsp), .mem_req(mem_req)
	);

	dl1_mem_model dl1_mem_model_inst (
		.clk_l1(clk_l1), .rst_n(rst_n), .mem_req(mem_req), .mem_rsp(mem_rsp),
		.read_count(read_count), .write_count(write_count)
	);

	always #2 clk_l1 = ~clk_l1;

	function automatic logic [31:0] make_addr(input logic [23:0] tag,
		input logic [3:0] set, input logic [1:0] word);
		return {tag, set, word, 2'b00};
	endfunction

	// Memory content before any write-back
	function automatic logic [31:0] mem_pattern(input logic [31:0] addr);
		return addr ^ 32'hA5A5_0000;
	endfunction

	function automatic void queue_xfer(input logic write, input logic [31:0] addr,
		input logic [31:0] wdata, input logic [31:0] exp_rdata, input int reads,
		input int writes);
		xfer_t x;
		x.write = write;
		x.addr = addr;
		x.wdata = wdata;
		x.exp_rdata = exp_rdata;
		x.exp_reads = 4'(reads);
		x.exp_writes = 4'(writes);
		xfers.push_back(x);
	endfunction

	function automatic void queue_read(input logic [23:0] tag, input logic [3:0] set,
		input logic [1:0] word, input int reads, input int writes);
		queue_xfer(1'b0, make_addr(tag, set, word), '0,
			mem_pattern(make_addr(tag, set, word)), reads, writes);
	endfunction

	//========================================
	// Transfer table
	//========================================

	task automatic build_table();
		// Cold miss followed by hits anywhere in the line
		queue_read(24'h000010, 4'd1, 2'd0, 1, 0);
		queue_read(24'h000010, 4'd1, 2'd3, 0, 0);
		queue_read(24'h000010, 4'd1, 2'd2, 0, 0);
		// Write hit stays in the cache
		queue_xfer(1'b1, make_addr(24'h000010, 4'd1, 2'd2), 32'h1111_2222, '0, 0, 0);
		queue_xfer(1'b0, make_addr(24'h000010, 4'd1, 2'd2), '0, 32'h1111_2222, 0, 0);
		// Both ways of set 5 dirty before a third tag forces write-backs
		queue_xfer(1'b1, make_addr(24'h000020, 4'd5, 2'd1), 32'hD1D1_0001, '0, 1, 0);
		queue_xfer(1'b1, make_addr(24'h000021, 4'd5, 2'd1), 32'hD2D2_0002, '0, 1, 0);
		queue_read(24'h000022, 4'd5, 2'd0, 1, 1);
		queue_xfer(1'b0, make_addr(24'h000020, 4'd5, 2'd1), '0, 32'hD1D1_0001, 1, 1);
		queue_xfer(1'b0, make_addr(24'h000021, 4'd5, 2'd1), '0, 32'hD2D2_0002, 1, 0);
		// Tags A B A C in set 9 so that C replaces B
		queue_read(24'h000030, 4'd9, 2'd0, 1, 0);
		queue_read(24'h000031, 4'd9, 2'd0, 1, 0);
		queue_read(24'h000030, 4'd9, 2'd1, 0, 0);
		queue_read(24'h000032, 4'd9, 2'd0, 1, 0);
		queue_read(24'h000030, 4'd9, 2'd2, 0, 0);
		queue_read(24'h000031, 4'd9, 2'd3, 1, 0);
	endtask

	task automatic run_xfer(input xfer_t x);
		int unsigned reads_before;
		int unsigned writes_before;
		int unsigned reads_done;
		int unsigned writes_done;
		int wait_states;
		logic done;
		logic [31:0] got;
		reads_before = read_count;
		writes_before = write_count;
		@(posedge clk_l1);
		#1;
		psel = 1'b1;
		penable = 1'b0;
		paddr = x.addr;
		pwrite = x.write;
		pwdata = x.wdata;
		@(posedge clk_l1);
		#1;
		penable = 1'b1;
		done = 1'b0;
		wait_states = 0;
		while (!done)
		begin
			@(negedge clk_l1);
			done = pready;
			if (!done)
				wait_states++;
		end
		got = prdata;
		assert (pslverr == 1'b0)
		else
		begin
			protocol_errors++;
			$display("** Error at %0t: pslverr = %b, expected 0", $time, pslverr);
		end
		@(posedge clk_l1);
		#1;
		psel = 1'b0;
		penable = 1'b0;
		reads_done = read_count - reads_before;
		writes_done = write_count - writes_before;
		if (!x.write)
		begin
			assert (got == x.exp_rdata)
			else
			begin
				data_errors++;
				$display("** Error at %0t: prdata = %h, expected %h (paddr %h)",
					$time, got, x.exp_rdata, x.addr);
			end
		end
		assert (reads_done == 32'(x.exp_reads))
		else
		begin
			traffic_errors++;
			$display("** Error at %0t: read_count delta = %0d, expected %0d (paddr %h)",
				$time, reads_done, x.exp_reads, x.addr);
		end
		assert (writes_done == 32'(x.exp_writes))
		else
		begin
			traffic_errors++;
			$display("** Error at %0t: write_count delta = %0d, expected %0d (paddr %h)",
				$time, writes_done, x.exp_writes, x.addr);
		end
		// A hit finishes in its first access cycle
		if ((x.exp_reads == 0) && (x.exp_writes == 0))
		begin
			assert (wait_states == 0)
			else
			begin
				protocol_errors++;
				$display("** Error at %0t: pready wait states = %0d, expected 0 (paddr %h)",
					$time, wait_states, x.addr);
			end
		end
	endtask

	//========================================
	// Main sequence
	//========================================

	initial
	begin
		clk_l1 = 1'b0;
		rst_n = 1'b0;
		psel = 1'b0;
		penable = 1'b0;
		paddr = '0;
		pwrite = 1'b0;
		pwdata = '0;
		data_errors = 0;
		traffic_errors = 0;
		protocol_errors = 0;
		build_table();
		timeout_limit = xfers.size() * 40;
		repeat (8) @(posedge clk_l1);
		#1;
		rst_n = 1'b1;
		@(negedge clk_l1);
		assert (pready == 1'b0)
		else
		begin
			protocol_errors++;
			$display("** Error at %0t: pready = %b, expected 0", $time, pready);
		end
		assert (mem_req.req == 1'b0)
		else
		begin
			protocol_errors++;
			$display("** Error at %0t: mem_req.req = %b, expected 0", $time, mem_req.req);
		end
		foreach (xfers[i])
			run_xfer(xfers[i]);
		$display("Errors: %0d data, %0d memory traffic, %0d protocol", data_errors,
			traffic_errors, protocol_errors);
		if (data_errors + traffic_errors + protocol_errors == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

	// Cycle budget counted from reset release
	initial
	begin : watchdog
		int cycles;
		cycles = 0;
		@(posedge rst_n);
		while (cycles < timeout_limit)
		begin
			@(posedge clk_l1);
			cycles++;
		end
		$display("Timeout: transfers did not finish within %0d cycles", timeout_limit);
		$display("TEST FAIL");
		$finish;
	end

endmodule
